// ==== logic/ao_periph_defs.svh ====
// Always-on peripheral block
// Address map, bus widths and the error read pattern

`ifndef AO_PERIPH_DEFS_SVH
`define AO_PERIPH_DEFS_SVH

// Bits 31 to 12 of every access must match this base
`define AO_BASE_ADDR 32'h2000_0000

`define AO_DATA_W 32

// 256-byte windows inside the block
`define SOC_CTRL_OFS  32'h0000_0000
`define FAST_INTR_OFS 32'h0000_0100
`define GPIO_OFS      32'h0000_0200

`define FAST_INTR_N 15
`define GPIO_N      8

`define ERR_RDATA 32'hbadcab1e

`endif

// ==== logic/ao_periph_pkg.sv ====
// Always-on peripheral types
// Core-side bus, register access and GPIO pin structs

`include "ao_periph_defs.svh"
`default_nettype none

package ao_periph_pkg;

  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`AO_DATA_W/8-1:0]   be;
    logic [31:0]               addr;
    logic [`AO_DATA_W-1:0]     wdata;
  } bus_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err;
    logic [`AO_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Single-cycle register access
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`AO_DATA_W/8-1:0] wstrb;
    logic [31:0]             addr;
    logic [`AO_DATA_W-1:0]   wdata;
  } reg_req_t;

  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [`AO_DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [`GPIO_N-1:0] out;
    logic [`GPIO_N-1:0] oe;
  } gpio_pins_t;

endpackage

`default_nettype wire

// ==== logic/bus_to_reg.sv ====
// Core bus to register bridge
// Grants at once, forwards legal accesses, answers one cycle later

`include "ao_periph_defs.svh"
`default_nettype none

module bus_to_reg (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::bus_req_t bus_req_i,
  output ao_periph_pkg::bus_rsp_t bus_rsp_o,
  output ao_periph_pkg::reg_req_t reg_req_o,
  input  ao_periph_pkg::reg_rsp_t reg_rsp_i
);

  logic                  addr_ok;
  logic                  rvalid_q;
  logic                  err_q;
  logic [`AO_DATA_W-1:0] rdata_q;

  // Word aligned and inside the 4 KiB block
  assign addr_ok = (bus_req_i.addr[1:0] == 2'b00) &&
                   ({bus_req_i.addr[31:12], 12'h000} == `AO_BASE_ADDR);

  assign reg_req_o.valid = bus_req_i.req & addr_ok;
  assign reg_req_o.write = bus_req_i.we;
  assign reg_req_o.wstrb = bus_req_i.be;
  assign reg_req_o.addr  = bus_req_i.addr;
  assign reg_req_o.wdata = bus_req_i.wdata;

  // No back-pressure
  assign bus_rsp_o.gnt    = bus_req_i.req;
  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.err    = err_q;
  assign bus_rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
    end
  end

  // Response payload, captured in the grant cycle
  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      if (addr_ok) begin
        err_q   <= reg_rsp_i.error;
        rdata_q <= reg_rsp_i.rdata;
      end else begin
        err_q   <= 1'b1;
        rdata_q <= `ERR_RDATA;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_demux.sv ====
// Register access decoder
// Routes by address bits 11:8 to one of three peripherals

`include "ao_periph_defs.svh"
`default_nettype none

module reg_demux (
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output ao_periph_pkg::reg_req_t soc_req_o,
  output ao_periph_pkg::reg_req_t intr_req_o,
  output ao_periph_pkg::reg_req_t gpio_req_o,
  input  ao_periph_pkg::reg_rsp_t soc_rsp_i,
  input  ao_periph_pkg::reg_rsp_t intr_rsp_i,
  input  ao_periph_pkg::reg_rsp_t gpio_rsp_i
);

  import ao_periph_pkg::*;

  // Answer for any window outside the map
  localparam reg_rsp_t HOLE_RSP = '{ready: 1'b1, error: 1'b1, rdata: `ERR_RDATA};

  logic [11:0] win_base;
  logic        sel_soc;
  logic        sel_intr;
  logic        sel_gpio;

  assign win_base = {reg_req_i.addr[11:8], 8'h00};

  assign sel_soc  = (win_base == `SOC_CTRL_OFS);
  assign sel_intr = (win_base == `FAST_INTR_OFS);
  assign sel_gpio = (win_base == `GPIO_OFS);

  always_comb begin
    soc_req_o  = reg_req_i;
    intr_req_o = reg_req_i;
    gpio_req_o = reg_req_i;

    // Only the selected window sees valid
    soc_req_o.valid  = reg_req_i.valid & sel_soc;
    intr_req_o.valid = reg_req_i.valid & sel_intr;
    gpio_req_o.valid = reg_req_i.valid & sel_gpio;
  end

  always_comb begin
    if (sel_soc) begin
      reg_rsp_o = soc_rsp_i;
    end else if (sel_intr) begin
      reg_rsp_o = intr_rsp_i;
    end else if (sel_gpio) begin
      reg_rsp_o = gpio_rsp_i;
    end else begin
      reg_rsp_o = HOLE_RSP;
    end
  end

endmodule

`default_nettype wire

// ==== logic/soc_ctrl.sv ====
// SoC control registers
// Program exit flag and value, plus boot pin readback

`include "ao_periph_defs.svh"
`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    boot_select_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    exit_valid_o,
  output logic [`AO_DATA_W-1:0]   exit_value_o
);

  localparam logic [7:0] EXIT_VALID_OFS  = 8'h00;
  localparam logic [7:0] EXIT_VALUE_OFS  = 8'h04;
  localparam logic [7:0] BOOT_SELECT_OFS = 8'h08;

  logic                  exit_valid_q;
  logic [`AO_DATA_W-1:0] exit_value_q;
  logic                  wr_en;
  logic                  hit;
  logic [`AO_DATA_W-1:0] rdata;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (reg_req_i.addr[7:0])
      EXIT_VALID_OFS:  rdata[0] = exit_valid_q;
      EXIT_VALUE_OFS:  rdata    = exit_value_q;
      BOOT_SELECT_OFS: rdata[0] = boot_select_i;
      default:         hit      = 1'b0;
    endcase
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = ~hit;
  assign reg_rsp_o.rdata = hit ? rdata : `ERR_RDATA;

  // Writes to BOOT_SELECT fall through silently
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (reg_req_i.addr[7:0] == EXIT_VALID_OFS && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (reg_req_i.addr[7:0] == EXIT_VALUE_OFS) begin
        for (int b = 0; b < `AO_DATA_W/8; b++) begin
          if (reg_req_i.wstrb[b]) begin
            exit_value_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== logic/fast_intr_ctrl.sv ====
// Fast interrupt controller
// Sticky pending bits with write-one-to-clear, masked by ENABLE

`include "ao_periph_defs.svh"
`default_nettype none

module fast_intr_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_periph_pkg::reg_req_t  reg_req_i,
  output ao_periph_pkg::reg_rsp_t  reg_rsp_o,
  input  logic [`FAST_INTR_N-1:0]  fast_intr_i,
  output logic [`FAST_INTR_N-1:0]  fast_intr_o
);

  localparam logic [7:0] PENDING_OFS = 8'h00;
  localparam logic [7:0] ENABLE_OFS  = 8'h04;

  logic [`FAST_INTR_N-1:0] pending_q;
  logic [`FAST_INTR_N-1:0] enable_q;
  logic [`FAST_INTR_N-1:0] intr_q;
  logic [`FAST_INTR_N-1:0] wmask;
  logic [`FAST_INTR_N-1:0] clear;
  logic                    wr_pending;
  logic                    wr_enable;
  logic                    hit;
  logic [`AO_DATA_W-1:0]   rdata;

  // Per-bit strobe from the byte lanes
  always_comb begin
    for (int i = 0; i < `FAST_INTR_N; i++) begin
      wmask[i] = reg_req_i.wstrb[i/8];
    end
  end

  assign wr_pending = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr[7:0] == PENDING_OFS);
  assign wr_enable  = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr[7:0] == ENABLE_OFS);
  assign clear      = wr_pending ? (reg_req_i.wdata[`FAST_INTR_N-1:0] & wmask) : '0;

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (reg_req_i.addr[7:0])
      PENDING_OFS: rdata[`FAST_INTR_N-1:0] = pending_q;
      ENABLE_OFS:  rdata[`FAST_INTR_N-1:0] = enable_q;
      default:     hit = 1'b0;
    endcase
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = ~hit;
  assign reg_rsp_o.rdata = hit ? rdata : `ERR_RDATA;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      intr_q    <= '0;
    end else begin
      // A new set beats a clear in the same cycle
      pending_q <= (pending_q & ~clear) | fast_intr_i;
      if (wr_enable) begin
        enable_q <= (enable_q & ~wmask) | (reg_req_i.wdata[`FAST_INTR_N-1:0] & wmask);
      end
      intr_q <= pending_q & enable_q;
    end
  end

  assign fast_intr_o = intr_q;

endmodule

`default_nettype wire

// ==== logic/gpio.sv ====
// GPIO block
// Synchronized inputs, output and enable registers, rising-edge interrupts

`include "ao_periph_defs.svh"
`default_nettype none

module gpio (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::reg_req_t   reg_req_i,
  output ao_periph_pkg::reg_rsp_t   reg_rsp_o,
  input  logic [`GPIO_N-1:0]        gpio_i,
  output ao_periph_pkg::gpio_pins_t pins_o,
  output logic [`GPIO_N-1:0]        intr_gpio_o
);

  localparam logic [7:0] IN_OFS          = 8'h00;
  localparam logic [7:0] OUT_OFS         = 8'h04;
  localparam logic [7:0] OE_OFS          = 8'h08;
  localparam logic [7:0] INTR_EN_OFS     = 8'h0c;
  localparam logic [7:0] INTR_STATUS_OFS = 8'h10;

  logic [`GPIO_N-1:0]    in_meta_q;
  logic [`GPIO_N-1:0]    in_sync_q;
  logic [`GPIO_N-1:0]    in_prev_q;
  logic [`GPIO_N-1:0]    out_q;
  logic [`GPIO_N-1:0]    oe_q;
  logic [`GPIO_N-1:0]    intr_en_q;
  logic [`GPIO_N-1:0]    status_q;
  logic [`GPIO_N-1:0]    wmask;
  logic [`GPIO_N-1:0]    wdata;
  logic [`GPIO_N-1:0]    rise;
  logic [`GPIO_N-1:0]    clear;
  logic                  wr_en;
  logic                  hit;
  logic [`AO_DATA_W-1:0] rdata;

  always_comb begin
    for (int i = 0; i < `GPIO_N; i++) begin
      wmask[i] = reg_req_i.wstrb[i/8];
    end
  end

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign wdata = reg_req_i.wdata[`GPIO_N-1:0] & wmask;
  assign rise  = in_sync_q & ~in_prev_q;
  assign clear = (wr_en && reg_req_i.addr[7:0] == INTR_STATUS_OFS) ? wdata : '0;

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (reg_req_i.addr[7:0])
      IN_OFS:          rdata[`GPIO_N-1:0] = in_sync_q;
      OUT_OFS:         rdata[`GPIO_N-1:0] = out_q;
      OE_OFS:          rdata[`GPIO_N-1:0] = oe_q;
      INTR_EN_OFS:     rdata[`GPIO_N-1:0] = intr_en_q;
      INTR_STATUS_OFS: rdata[`GPIO_N-1:0] = status_q;
      default:         hit = 1'b0;
    endcase
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = ~hit;
  assign reg_rsp_o.rdata = hit ? rdata : `ERR_RDATA;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      // Two-flop synchronizer, then one stage for edge detect
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
      status_q  <= (status_q & ~clear) | (rise & intr_en_q);
      if (wr_en) begin
        case (reg_req_i.addr[7:0])
          OUT_OFS:     out_q     <= (out_q & ~wmask) | wdata;
          OE_OFS:      oe_q      <= (oe_q & ~wmask) | wdata;
          INTR_EN_OFS: intr_en_q <= (intr_en_q & ~wmask) | wdata;
          default:     ;
        endcase
      end
    end
  end

  assign pins_o.out  = out_q;
  assign pins_o.oe   = oe_q;
  assign intr_gpio_o = status_q;

endmodule

`default_nettype wire

// ==== logic/ao_peripheral_subsystem.sv ====
// Always-on peripheral subsystem
// Bus bridge, address decoder, SoC control, fast interrupts and GPIO

`include "ao_periph_defs.svh"
`default_nettype none

module ao_peripheral_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  ao_periph_pkg::bus_req_t   bus_req_i,
  output ao_periph_pkg::bus_rsp_t   bus_rsp_o,

  // SoC control
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output logic [`AO_DATA_W-1:0]     exit_value_o,

  input  logic [`FAST_INTR_N-1:0]   fast_intr_i,
  output logic [`FAST_INTR_N-1:0]   fast_intr_o,

  // GPIO pins
  input  logic [`GPIO_N-1:0]        gpio_i,
  output ao_periph_pkg::gpio_pins_t gpio_pins_o,
  output logic [`GPIO_N-1:0]        intr_gpio_o
);

  import ao_periph_pkg::*;

  reg_req_t periph_req;
  reg_rsp_t periph_rsp;
  reg_req_t soc_req;
  reg_rsp_t soc_rsp;
  reg_req_t intr_req;
  reg_rsp_t intr_rsp;
  reg_req_t gpio_req;
  reg_rsp_t gpio_rsp;

  bus_to_reg bus_to_reg_i (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_rsp_o,
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i  (periph_req),
    .reg_rsp_o  (periph_rsp),
    .soc_req_o  (soc_req),
    .intr_req_o (intr_req),
    .gpio_req_o (gpio_req),
    .soc_rsp_i  (soc_rsp),
    .intr_rsp_i (intr_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .boot_select_i,
    .reg_req_i (soc_req),
    .reg_rsp_o (soc_rsp),
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (intr_req),
    .reg_rsp_o (intr_rsp),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (gpio_req),
    .reg_rsp_o (gpio_rsp),
    .gpio_i,
    .pins_o    (gpio_pins_o),
    .intr_gpio_o
  );

endmodule

`default_nettype wire

// ==== verif/ao_periph_properties.sv ====
// Bus timing checks for the always-on bridge
// Bound to bus_to_reg, one rvalid per grant in the next cycle

`default_nettype none

module ao_periph_properties (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input ao_periph_pkg::bus_rsp_t bus_rsp_i
);

  property rvalid_after_gnt;
    @(posedge clk_i) disable iff (!rst_n_i)
      bus_rsp_i.gnt |=> bus_rsp_i.rvalid;
  endproperty

  // Every rvalid needs a grant one cycle before
  property no_stray_rvalid;
    @(posedge clk_i) disable iff (!rst_n_i)
      bus_rsp_i.rvalid |-> $past(bus_rsp_i.gnt);
  endproperty

  property rvalid_low_after_reset;
    @(posedge clk_i) $rose(rst_n_i) |-> !bus_rsp_i.rvalid;
  endproperty

  rvalid_after_gnt_a: assert property (rvalid_after_gnt)
    else $error("rvalid missing one cycle after a grant");

  no_stray_rvalid_a: assert property (no_stray_rvalid)
    else $error("rvalid without a grant in the previous cycle");

  rvalid_low_after_reset_a: assert property (rvalid_low_after_reset)
    else $error("rvalid high in the first cycle after reset");

endmodule

bind bus_to_reg ao_periph_properties props0 (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .bus_rsp_i (bus_rsp_o)
);

`default_nettype wire

// ==== verif/ao_periph_tb.sv ====
// Testbench for the always-on peripheral subsystem
// Random bus traffic against a register model, plus pin-level checks

`include "ao_periph_defs.svh"
`default_nettype none

module ao_periph_tb;

  import ao_periph_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int RAND_ACCESSES   = 64;
  localparam int OTHER_ACCESSES  = 40;
  localparam int PULSE_CYCLES    = 20;
  localparam int PIN_STEPS       = 6;
  localparam int WATCHDOG_CYCLES = (RAND_ACCESSES + OTHER_ACCESSES) * 8
                                   + PULSE_CYCLES + PIN_STEPS * 8 + 100;

  localparam logic [31:0] EXIT_VALID_A  = `AO_BASE_ADDR + `SOC_CTRL_OFS + 32'h00;
  localparam logic [31:0] EXIT_VALUE_A  = `AO_BASE_ADDR + `SOC_CTRL_OFS + 32'h04;
  localparam logic [31:0] BOOT_SEL_A    = `AO_BASE_ADDR + `SOC_CTRL_OFS + 32'h08;
  localparam logic [31:0] PENDING_A     = `AO_BASE_ADDR + `FAST_INTR_OFS + 32'h00;
  localparam logic [31:0] ENABLE_A      = `AO_BASE_ADDR + `FAST_INTR_OFS + 32'h04;
  localparam logic [31:0] GPIO_IN_A     = `AO_BASE_ADDR + `GPIO_OFS + 32'h00;
  localparam logic [31:0] GPIO_OUT_A    = `AO_BASE_ADDR + `GPIO_OFS + 32'h04;
  localparam logic [31:0] GPIO_OE_A     = `AO_BASE_ADDR + `GPIO_OFS + 32'h08;
  localparam logic [31:0] INTR_EN_A     = `AO_BASE_ADDR + `GPIO_OFS + 32'h0c;
  localparam logic [31:0] INTR_STATUS_A = `AO_BASE_ADDR + `GPIO_OFS + 32'h10;

  logic                    clk;
  logic                    rst_n;
  bus_req_t                bus_req;
  bus_rsp_t                bus_rsp;
  logic                    boot_select;
  logic                    exit_valid;
  logic [`AO_DATA_W-1:0]   exit_value;
  logic [`FAST_INTR_N-1:0] fast_intr_in;
  logic [`FAST_INTR_N-1:0] fast_intr_out;
  logic [`GPIO_N-1:0]      gpio_in;
  gpio_pins_t              gpio_pins;
  logic [`GPIO_N-1:0]      intr_gpio;

  // Register model, reset values
  logic                    m_exit_valid = 1'b0;
  logic [31:0]             m_exit_value = '0;
  logic [`FAST_INTR_N-1:0] m_pending    = '0;
  logic [`FAST_INTR_N-1:0] m_enable     = '0;
  logic [`GPIO_N-1:0]      m_out        = '0;
  logic [`GPIO_N-1:0]      m_oe         = '0;
  logic [`GPIO_N-1:0]      m_intr_en    = '0;
  logic [`GPIO_N-1:0]      m_status     = '0;
  logic [`GPIO_N-1:0]      m_in         = '0;

  bus_rsp_t    exp_q[$];
  logic [31:0] lfsr_state = 32'hcb3ff844;
  logic        granted    = 1'b0;
  logic        live       = 1'b0;
  int          errors     = 0;
  int          checks     = 0;
  int          tests_run  = 0;
  int          tests_bad  = 0;
  int          last_errors = 0;

  ao_peripheral_subsystem dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .bus_req_i     (bus_req),
    .bus_rsp_o     (bus_rsp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .gpio_i        (gpio_in),
    .gpio_pins_o   (gpio_pins),
    .intr_gpio_o   (intr_gpio)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic lfsr_step();
    logic bit_out;
    bit_out    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return bit_out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic logic [31:0] strobe_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Expected response of one access, applying its write to the model
  function automatic bus_rsp_t model_access(input bus_req_t r);
    bus_rsp_t    rsp;
    logic [31:0] wd;
    logic [31:0] rd;
    logic        ok;
    wd = r.wdata & strobe_mask(r.be);
    rd = '0;
    ok = (r.addr[1:0] == 2'b00) && (r.addr[31:12] == `AO_BASE_ADDR >> 12);
    if (ok) begin
      case (r.addr)
        EXIT_VALID_A: begin
          rd[0] = m_exit_valid;
          if (r.we && r.be[0]) begin
            m_exit_valid = r.wdata[0];
          end
        end
        EXIT_VALUE_A: begin
          rd = m_exit_value;
          if (r.we) begin
            m_exit_value = (m_exit_value & ~strobe_mask(r.be)) | wd;
          end
        end
        BOOT_SEL_A: rd[0] = boot_select;
        PENDING_A: begin
          rd[`FAST_INTR_N-1:0] = m_pending;
          if (r.we) begin
            m_pending = m_pending & ~wd[`FAST_INTR_N-1:0];
          end
        end
        ENABLE_A: begin
          rd[`FAST_INTR_N-1:0] = m_enable;
          if (r.we) begin
            m_enable = (m_enable & ~strobe_mask(r.be)) | wd[`FAST_INTR_N-1:0];
          end
        end
        GPIO_IN_A: rd[`GPIO_N-1:0] = m_in;
        GPIO_OUT_A: begin
          rd[`GPIO_N-1:0] = m_out;
          if (r.we && r.be[0]) begin
            m_out = wd[`GPIO_N-1:0];
          end
        end
        GPIO_OE_A: begin
          rd[`GPIO_N-1:0] = m_oe;
          if (r.we && r.be[0]) begin
            m_oe = wd[`GPIO_N-1:0];
          end
        end
        INTR_EN_A: begin
          rd[`GPIO_N-1:0] = m_intr_en;
          if (r.we && r.be[0]) begin
            m_intr_en = wd[`GPIO_N-1:0];
          end
        end
        INTR_STATUS_A: begin
          rd[`GPIO_N-1:0] = m_status;
          if (r.we) begin
            m_status = m_status & ~wd[`GPIO_N-1:0];
          end
        end
        default: ok = 1'b0;
      endcase
    end
    rsp.gnt    = 1'b1;
    rsp.rvalid = 1'b1;
    rsp.err    = !ok;
    rsp.rdata  = ok ? rd : `ERR_RDATA;
    return rsp;
  endfunction

  function automatic gpio_pins_t model_pins();
    gpio_pins_t p;
    p.out = m_out;
    p.oe  = m_oe;
    return p;
  endfunction

  task automatic check_bus_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
    checks++;
    if (got.err !== exp.err || got.rdata !== exp.rdata) begin
      $display("ERROR %0t: %s err %b rdata %h, expected err %b rdata %h",
               $time, what, got.err, got.rdata, exp.err, exp.rdata);
      errors++;
    end
  endtask

  task automatic check_pins(input gpio_pins_t got, input gpio_pins_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERROR %0t: %s out %h oe %h, expected out %h oe %h",
               $time, what, got.out, got.oe, exp.out, exp.oe);
      errors++;
    end
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Request and reset as the DUT saw them at the last rising edge
  always @(posedge clk) begin
    granted = rst_n && bus_req.req;
    live    = rst_n;
    check_value({31'b0, bus_rsp.gnt}, {31'b0, bus_req.req}, "gnt");
  end

  always @(negedge clk) begin : compare_rsp
    bus_rsp_t exp;
    if (live) begin
      if (bus_rsp.rvalid !== granted) begin
        $display("Response timing is wrong at time %0t: rvalid is %b, grant a cycle before was %b",
                 $time, bus_rsp.rvalid, granted);
        errors++;
      end
      if (bus_rsp.rvalid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived at time %0t with no access waiting for it", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_bus_rsp(bus_rsp, exp, "bus response");
        end
      end
    end
  end

  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata);
    bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    @(negedge clk);
    bus_req = r;
    exp_q.push_back(model_access(r));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    bus_access(1'b1, addr, 4'hf, data);
  endtask

  task automatic read_word(input logic [31:0] addr);
    bus_access(1'b0, addr, 4'h0, 32'h0);
  endtask

  // Drop req and wait until every response has been checked
  task automatic wait_idle();
    @(negedge clk);
    bus_req = '0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == last_errors) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: FAIL with %0d errors", name, errors - last_errors);
      tests_bad++;
    end
    last_errors = errors;
  endtask

  task automatic test_random_rw();
    int          sel;
    logic [31:0] addr;
    for (int i = 0; i < RAND_ACCESSES; i++) begin
      sel = rand_bits(2);
      case (sel)
        0:       addr = EXIT_VALUE_A;
        1:       addr = ENABLE_A;
        2:       addr = GPIO_OUT_A;
        default: addr = GPIO_OE_A;
      endcase
      bus_access(rand_bits(1), addr, rand_bits(4), rand_bits(32));
    end
    wait_idle();
    check_pins(gpio_pins, model_pins(), "gpio pins");
    report_test("random_rw");
  endtask

  task automatic test_errors();
    write_word(`AO_BASE_ADDR + 32'h206, rand_bits(32));
    write_word(EXIT_VALUE_A + 32'h1, rand_bits(32));
    write_word(32'h3000_0004, rand_bits(32));
    write_word(32'h2000_1104, rand_bits(32));
    write_word(`AO_BASE_ADDR + 32'h304, rand_bits(32));
    read_word(`AO_BASE_ADDR + 32'h300);
    write_word(`AO_BASE_ADDR + 32'h00c, rand_bits(32));
    write_word(`AO_BASE_ADDR + 32'h108, rand_bits(32));
    write_word(`AO_BASE_ADDR + 32'h214, rand_bits(32));
    read_word(EXIT_VALID_A);
    read_word(EXIT_VALUE_A);
    read_word(ENABLE_A);
    read_word(GPIO_OUT_A);
    read_word(GPIO_OE_A);
    wait_idle();
    report_test("errors");
  endtask

  task automatic test_soc_ctrl();
    @(negedge clk);
    boot_select = 1'b1;
    write_word(EXIT_VALUE_A, rand_bits(32));
    write_word(EXIT_VALID_A, 32'h1);
    read_word(BOOT_SEL_A);
    wait_idle();
    check_value({31'b0, exit_valid}, {31'b0, m_exit_valid}, "exit_valid_o");
    check_value(exit_value, m_exit_value, "exit_value_o");
    @(negedge clk);
    boot_select = 1'b0;
    read_word(BOOT_SEL_A);
    read_word(EXIT_VALID_A);
    wait_idle();
    report_test("soc_ctrl");
  endtask

  task automatic test_fast_intr();
    logic [`FAST_INTR_N-1:0] pulse;
    write_word(ENABLE_A, rand_bits(`FAST_INTR_N));
    wait_idle();
    for (int i = 0; i < PULSE_CYCLES; i++) begin
      @(negedge clk);
      pulse        = rand_bits(`FAST_INTR_N) & rand_bits(`FAST_INTR_N);
      fast_intr_in = pulse;
      m_pending    = m_pending | pulse;
    end
    @(negedge clk);
    fast_intr_in = '0;
    repeat (2) @(negedge clk);
    check_value(32'(fast_intr_out), 32'(m_pending & m_enable), "fast_intr_o");
    read_word(PENDING_A);
    write_word(PENDING_A, rand_bits(`FAST_INTR_N));
    read_word(PENDING_A);
    wait_idle();
    repeat (2) @(negedge clk);
    check_value(32'(fast_intr_out), 32'(m_pending & m_enable), "fast_intr_o after clear");
    report_test("fast_intr");
  endtask

  task automatic test_gpio();
    logic [`GPIO_N-1:0] pins;
    write_word(GPIO_OUT_A, rand_bits(32));
    write_word(GPIO_OE_A, rand_bits(32));
    write_word(INTR_EN_A, rand_bits(32));
    wait_idle();
    check_pins(gpio_pins, model_pins(), "gpio pins");
    for (int i = 0; i < PIN_STEPS; i++) begin
      @(negedge clk);
      pins     = rand_bits(`GPIO_N);
      gpio_in  = pins;
      m_status = m_status | (pins & ~m_in & m_intr_en);
      m_in     = pins;
      repeat (3) @(negedge clk);
      read_word(GPIO_IN_A);
      wait_idle();
      check_value(32'(intr_gpio), 32'(m_status), "intr_gpio_o");
    end
    read_word(INTR_STATUS_A);
    write_word(INTR_STATUS_A, rand_bits(`GPIO_N) & m_status);
    read_word(INTR_STATUS_A);
    wait_idle();
    check_value(32'(intr_gpio), 32'(m_status), "intr_gpio_o after clear");
    report_test("gpio");
  endtask

  initial begin
    bus_req      = '0;
    boot_select  = 1'b0;
    fast_intr_in = '0;
    gpio_in      = '0;
    rst_n        = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value({31'b0, exit_valid}, 32'h0, "exit_valid_o after reset");
    check_value(32'(fast_intr_out), 32'h0, "fast_intr_o after reset");
    check_value(32'(intr_gpio), 32'h0, "intr_gpio_o after reset");
    check_pins(gpio_pins, '0, "gpio pins after reset");
    report_test("reset");

    test_random_rw();
    test_errors();
    test_soc_ctrl();
    test_fast_intr();
    test_gpio();

    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d cycles, stopping", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/ao_periph_pkg.sv
logic/bus_to_reg.sv
logic/reg_demux.sv
logic/soc_ctrl.sv
logic/fast_intr_ctrl.sv
logic/gpio.sv
logic/ao_peripheral_subsystem.sv
verif/ao_periph_properties.sv
verif/ao_periph_tb.sv
